// File: verilog/dcache_pkg.sv
// geometry is fixed here; changing SET_BITS or OFFSET_BITS reshapes the address union
package dcache_pkg;

	//------------------------------------------------------------
	// geometry
	//------------------------------------------------------------
	localparam int WORD_BITS       = 32;
	localparam int WORD_ADDR_BITS  = 30;  // processor word address
	localparam int OFFSET_BITS     = 2;   // word within block
	localparam int SET_BITS        = 2;
	localparam int TAG_BITS        = WORD_ADDR_BITS - SET_BITS - OFFSET_BITS;
	localparam int BLOCK_ADDR_BITS = WORD_ADDR_BITS - OFFSET_BITS;
	localparam int NUM_WAYS        = 2;
	localparam int NUM_SETS        = 1 << SET_BITS;
	localparam int WORDS_PER_BLOCK = 1 << OFFSET_BITS;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [WORDS_PER_BLOCK*WORD_BITS-1:0] block_t;  // word 0 in low bits

	// cache view of a word address
	typedef struct packed {
		logic [TAG_BITS-1:0]    tag;
		logic [SET_BITS-1:0]    set;
		logic [OFFSET_BITS-1:0] offset;
	} cache_view_t;

	// memory view as block address plus word offset
	typedef struct packed {
		logic [BLOCK_ADDR_BITS-1:0] block_addr;
		logic [OFFSET_BITS-1:0]     offset;
	} mem_view_t;

	typedef union packed {
		cache_view_t cache;
		mem_view_t   mem;
	} proc_addr_u;

	typedef enum logic [1:0] {
		state_idle       = 2'd0,
		state_write_back = 2'd1,
		state_refill     = 2'd2
	} ctrl_state_e;

endpackage

// File: verilog/cache_array_if.sv
// lookup side is combinational; rd_word and victim_block follow addr within the same cycle
`timescale 1ns/1ps

interface cache_array_if;
	import dcache_pkg::*;

	//------------------------------------------------------------
	// from the controller
	//------------------------------------------------------------
	proc_addr_u addr;
	logic       word_wr;      // single word write on a write hit
	word_t      wdata;
	logic       refill_wr;    // whole block from memory
	block_t     refill_data;
	logic       fill_way;

	// from the tag store
	logic                hit;  // does not look at the request
	logic                hit_way;
	logic                victim_way;
	logic                victim_valid;
	logic [TAG_BITS-1:0] victim_tag;

	// from the data store
	word_t  rd_word;
	block_t victim_block;

	modport ctrl (
		output addr, word_wr, wdata, refill_wr, refill_data, fill_way,
		input  hit, victim_way, victim_valid, victim_tag, victim_block
	);

	modport tags (
		input  addr, refill_wr, fill_way,
		output hit, hit_way, victim_way, victim_valid, victim_tag
	);

	modport data (
		input  addr, word_wr, wdata, refill_wr, refill_data, fill_way, hit_way, victim_way,
		output rd_word, victim_block
	);

endinterface

// File: verilog/cache_tag_store.sv
// any hitting lookup counts as a use for replacement, so a stale idle address also touches it
`timescale 1ns/1ps

module cache_tag_store (
	input logic        clk,
	input logic        rst_n,
	cache_array_if.tags arr
);
	import dcache_pkg::*;

	logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid [NUM_SETS];
	logic [NUM_SETS-1:0] mru;  // way used last in each set

	logic [SET_BITS-1:0] set_idx;
	logic [TAG_BITS-1:0] req_tag;
	logic [NUM_WAYS-1:0] match;
	logic                victim;

	assign set_idx = arr.addr.cache.set;
	assign req_tag = arr.addr.cache.tag;

	//------------------------------------------------------------
	// lookup
	//------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			// full tag compare gated by valid
			match[w] = valid[set_idx][w] && (tag_mem[set_idx][w] == req_tag);
		end
	end

	assign arr.hit     = |match;
	assign arr.hit_way = match[1];

	// empty way first, then the one not used last
	always_comb begin
		if (!valid[set_idx][0]) begin
			victim = 1'b0;
		end else if (!valid[set_idx][1]) begin
			victim = 1'b1;
		end else begin
			victim = ~mru[set_idx];
		end
	end

	assign arr.victim_way   = victim;
	assign arr.victim_valid = valid[set_idx][victim];
	assign arr.victim_tag   = tag_mem[set_idx][victim];

	//------------------------------------------------------------
	// update
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (arr.refill_wr) begin
			tag_mem[set_idx][arr.fill_way] <= req_tag;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
			end
			mru <= '0;
		end else if (arr.refill_wr) begin
			valid[set_idx][arr.fill_way] <= 1'b1;
			mru[set_idx]                 <= arr.fill_way;
		end else if (arr.hit) begin
			mru[set_idx] <= arr.hit_way;  // hit access
		end
	end

	// a refill into a set already holding the tag would leave two copies
	a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(match))
		else $error("tag matches both ways of set %0d", set_idx);

endmodule

// File: verilog/cache_data_store.sv
// data array has no reset; contents are only meaningful for ways marked valid in the tag store
`timescale 1ns/1ps

module cache_data_store (
	input logic         clk,
	cache_array_if.data arr
);
	import dcache_pkg::*;

	word_t words [NUM_SETS][NUM_WAYS][WORDS_PER_BLOCK];

	logic [SET_BITS-1:0]    set_idx;
	logic [OFFSET_BITS-1:0] word_idx;

	assign set_idx  = arr.addr.cache.set;
	assign word_idx = arr.addr.cache.offset;

	//------------------------------------------------------------
	// read side
	//------------------------------------------------------------
	assign arr.rd_word = words[set_idx][arr.hit_way][word_idx];

	// whole victim block for write back
	always_comb begin
		for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
			arr.victim_block[w*WORD_BITS +: WORD_BITS] = words[set_idx][arr.victim_way][w];
		end
	end

	//------------------------------------------------------------
	// write side
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (arr.refill_wr) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
				words[set_idx][arr.fill_way][w] <= arr.refill_data[w*WORD_BITS +: WORD_BITS];
			end
		end else if (arr.word_wr) begin
			words[set_idx][arr.hit_way][word_idx] <= arr.wdata;  // write hit
		end
	end

endmodule

// File: verilog/cache_ctrl.sv
// blocking controller handling one request at a time; the request must stay unchanged while stalled
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   proc_read,
	input  logic                                   proc_write,
	input  logic [dcache_pkg::WORD_ADDR_BITS-1:0]  proc_addr,
	input  dcache_pkg::word_t                      proc_wdata,
	output logic                                   proc_stall,
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic [dcache_pkg::BLOCK_ADDR_BITS-1:0] mem_addr,
	output dcache_pkg::block_t                     mem_wdata,
	input  dcache_pkg::block_t                     mem_rdata,
	input  logic                                   mem_ready,
	cache_array_if.ctrl                            arr
);
	import dcache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic        req;
	logic        idle_hit;

	assign req      = proc_read | proc_write;
	assign idle_hit = (state == state_idle) && arr.hit;

	//------------------------------------------------------------
	// array controls
	//------------------------------------------------------------
	assign arr.addr        = proc_addr;
	assign arr.wdata       = proc_wdata;
	assign arr.word_wr     = idle_hit && proc_write;
	assign arr.refill_data = mem_rdata;
	assign arr.refill_wr   = (state == state_refill) && mem_ready;
	assign arr.fill_way    = arr.victim_way;  // stable until the refill edge

	// hit completes with no added cycle
	assign proc_stall = req && !idle_hit;

	//------------------------------------------------------------
	// memory port
	//------------------------------------------------------------
	assign mem_read  = (state == state_refill);
	assign mem_write = (state == state_write_back);
	assign mem_wdata = arr.victim_block;

	always_comb begin
		if (state == state_write_back) begin
			// victim block lives in the same set
			mem_addr = {arr.victim_tag, arr.addr.mem.block_addr[SET_BITS-1:0]};
		end else begin
			mem_addr = arr.addr.mem.block_addr;
		end
	end

	//------------------------------------------------------------
	// miss FSM
	//------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			state_idle: begin
				if (req && !arr.hit) begin
					state_nxt = arr.victim_valid ? state_write_back : state_refill;
				end
			end
			state_write_back: begin
				if (mem_ready) begin
					state_nxt = state_refill;
				end
			end
			state_refill: begin
				if (mem_ready) begin
					state_nxt = state_idle;  // request retries as a hit
				end
			end
			default: begin
				state_nxt = state_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= state_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// memory request held until accepted
	a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr)))
		else $error("write back dropped before mem_ready");

endmodule

// File: verilog/dcache.sv
// two-way write-back data cache, four sets of four-word blocks, allocate on write miss
`timescale 1ns/1ps

module dcache (
	input  logic                                   clk,
	input  logic                                   rst_n,

	//------------------------------------------------------------
	// processor side
	//------------------------------------------------------------
	input  logic                                   proc_read,
	input  logic                                   proc_write,
	input  logic [dcache_pkg::WORD_ADDR_BITS-1:0]  proc_addr,
	input  dcache_pkg::word_t                      proc_wdata,
	output dcache_pkg::word_t                      proc_rdata,
	output logic                                   proc_stall,

	//------------------------------------------------------------
	// memory side
	//------------------------------------------------------------
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic [dcache_pkg::BLOCK_ADDR_BITS-1:0] mem_addr,
	output dcache_pkg::block_t                     mem_wdata,
	input  dcache_pkg::block_t                     mem_rdata,
	input  logic                                   mem_ready
);

	cache_array_if arr ();

	// read data comes straight from the array
	assign proc_rdata = arr.rd_word;

	cache_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.arr        (arr.ctrl)
	);

	// tags, valid bits, replacement
	cache_tag_store u_tags (
		.clk   (clk),
		.rst_n (rst_n),
		.arr   (arr.tags)
	);

	cache_data_store u_data (
		.clk (clk),
		.arr (arr.data)
	);

endmodule

// File: dv/slow_mem_model.sv
// only the low INDEX_BITS of mem_addr are decoded; latency is sampled when an access starts
`timescale 1ns/1ps

module slow_mem_model #(
	parameter int INDEX_BITS = 6
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [2:0]                             latency,   // extra wait cycles
	input  logic                                   mem_read,
	input  logic                                   mem_write,
	input  logic [dcache_pkg::BLOCK_ADDR_BITS-1:0] mem_addr,
	input  dcache_pkg::block_t                     mem_wdata,
	output dcache_pkg::block_t                     mem_rdata,
	output logic                                   mem_ready
);
	import dcache_pkg::*;

	block_t                blocks [1 << INDEX_BITS];
	logic                  busy;
	logic [2:0]            wait_cnt;
	logic [INDEX_BITS-1:0] idx;

	// start-up contents as a function of the full word address
	function automatic word_t init_word(input int word_addr);
		return (word_addr * 32'h0001_0001) ^ 32'hA55A_3CC3;
	endfunction

	initial begin
		for (int b = 0; b < (1 << INDEX_BITS); b++) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
				blocks[b][w*WORD_BITS +: WORD_BITS] = init_word(b * WORDS_PER_BLOCK + w);
			end
		end
	end

	assign idx       = mem_addr[INDEX_BITS-1:0];
	assign mem_rdata = blocks[idx];
	assign mem_ready = busy && (wait_cnt == 3'd0);  // one cycle per transfer

	//------------------------------------------------------------
	// access sequencing
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			wait_cnt <= 3'd0;
		end else if (mem_ready) begin
			busy <= 1'b0;  // transfer done at this edge
		end else if (busy) begin
			wait_cnt <= wait_cnt - 3'd1;
		end else if (mem_read || mem_write) begin
			busy     <= 1'b1;
			wait_cnt <= latency;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_ready && mem_write) begin
			blocks[idx] <= mem_wdata;
		end
	end

endmodule

// File: dv/dcache_tb.sv
// word addresses stay below 256 so the shadow array and the memory model cover them fully
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;
	localparam int SHADOW_WORDS   = 256;
	localparam int RANDOM_OPS     = 300;

	logic                       clk = 1'b0;
	logic                       rst_n;
	logic                       proc_read;
	logic                       proc_write;
	logic [WORD_ADDR_BITS-1:0]  proc_addr;
	word_t                      proc_wdata;
	word_t                      proc_rdata;
	logic                       proc_stall;
	logic                       mem_read;
	logic                       mem_write;
	logic [BLOCK_ADDR_BITS-1:0] mem_addr;
	block_t                     mem_wdata;
	block_t                     mem_rdata;
	logic                       mem_ready;
	logic [2:0]                 mem_latency = 3'd0;

	word_t       shadow [SHADOW_WORDS];
	logic [31:0] rng = 32'd93;
	string       test_name = "none";
	int          checks = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          err_at_start = 0;
	logic        timed_out = 1'b0;
	int          rd_xfers = 0;
	int          wr_xfers = 0;
	int          overlap_count = 0;
	logic [31:0] last_rd_addr = '0;
	logic [31:0] last_wr_addr = '0;
	block_t      last_wr_data = '0;

	always #20 clk = ~clk;

	dcache UUT (
		.clk(clk), .rst_n(rst_n),
		.proc_read(proc_read), .proc_write(proc_write), .proc_addr(proc_addr),
		.proc_wdata(proc_wdata), .proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	slow_mem_model u_mem (
		.clk(clk), .rst_n(rst_n), .latency(mem_latency),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic word_t pattern_word(input int word_addr);
		return (word_addr * 32'h0001_0001) ^ 32'hA55A_3CC3;
	endfunction

	// expected processor view of one word
	function automatic word_t expected_word(input logic [WORD_ADDR_BITS-1:0] addr);
		return shadow[addr[7:0]];
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	//------------------------------------------------------------
	// monitors and read compare at mid-cycle
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (mem_read && mem_write) overlap_count++;
			if (mem_ready && mem_read) begin
				rd_xfers++;
				last_rd_addr = mem_addr;
			end
			if (mem_ready && mem_write) begin
				wr_xfers++;
				last_wr_addr = mem_addr;
				last_wr_data = mem_wdata;
			end
			if (proc_read && !proc_stall) begin
				check_value("read data", expected_word(proc_addr), proc_rdata);
			end
			if (proc_write && !proc_stall) begin
				shadow[proc_addr[7:0]] = proc_wdata;  // write lands at the next edge
			end
		end
	end

	always @(negedge clk) begin
		rng = xorshift(rng);
		mem_latency = rng[2:0];
	end

	// one request held until proc_stall is low
	task automatic do_request(input logic wr, input logic [WORD_ADDR_BITS-1:0] addr,
			input word_t data, output int stalls, output word_t rdata);
		logic done;
		int   cycles;
		done   = 1'b0;
		cycles = 0;
		rdata  = '0;
		@(posedge clk);
		#1;
		proc_read  = !wr;
		proc_write = wr;
		proc_addr  = addr;
		proc_wdata = data;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (!proc_stall) begin
				done  = 1'b1;
				rdata = proc_rdata;
			end else begin
				cycles++;
			end
		end
		@(posedge clk);
		#1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		if (!done) begin
			timed_out = 1'b1;
			$display("ERROR: request to word address %h never completed", addr);
		end
		stalls = cycles;
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		err_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (timed_out) begin
			tests_failed++;
			$display("test %s: did not finish", test_name);
		end else if (errors != err_at_start) begin
			tests_failed++;
			$display("test %s: %0d mismatches", test_name, errors - err_at_start);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	//------------------------------------------------------------
	// tests
	//------------------------------------------------------------
	task automatic directed_tests();
		int    stalls;
		int    rd0;
		int    wr0;
		word_t data;
		begin_test("reset");
		@(negedge clk);
		check_value("mem_read", 0, mem_read);
		check_value("mem_write", 0, mem_write);
		check_value("idle stall", 0, proc_stall);
		end_test();

		begin_test("read_miss");
		rd0 = rd_xfers;
		wr0 = wr_xfers;
		do_request(1'b0, 30'h10, '0, stalls, data);
		check_value("refill count", rd0 + 1, rd_xfers);
		check_value("refill address", 32'h4, last_rd_addr);
		check_value("pattern word", pattern_word(32'h10), data);
		check_value("write backs", wr0, wr_xfers);  // victim was empty
		do_request(1'b0, 30'h11, '0, stalls, data);
		check_value("hit stall cycles", 0, stalls);
		check_value("refill count after hit", rd0 + 1, rd_xfers);
		end_test();

		begin_test("write_hit");
		rd0 = rd_xfers;
		wr0 = wr_xfers;
		do_request(1'b1, 30'h12, 32'hCAFE_0012, stalls, data);
		check_value("write stall cycles", 0, stalls);
		do_request(1'b0, 30'h12, '0, stalls, data);
		check_value("read stall cycles", 0, stalls);
		check_value("read back", 32'hCAFE_0012, data);
		check_value("memory reads", rd0, rd_xfers);
		check_value("memory writes", wr0, wr_xfers);
		end_test();

		// blocks 1, 5 and 9 all index set 1
		begin_test("eviction");
		do_request(1'b1, 30'h04, 32'h1111_0004, stalls, data);
		do_request(1'b1, 30'h15, 32'h5555_0015, stalls, data);
		wr0 = wr_xfers;
		do_request(1'b0, 30'h24, '0, stalls, data);
		check_value("miss stalled", 1, stalls != 0);
		check_value("write back count", wr0 + 1, wr_xfers);
		check_value("write back address", 32'h1, last_wr_addr);
		check_value("write back word", 32'h1111_0004, last_wr_data[31:0]);
		rd0 = rd_xfers;
		do_request(1'b0, 30'h04, '0, stalls, data);
		check_value("refetched word", 32'h1111_0004, data);
		check_value("refetch address", 32'h1, last_rd_addr);
		check_value("refetch count", rd0 + 1, rd_xfers);
		end_test();
	endtask

	task automatic random_test();
		int                        stalls;
		int                        overlap0;
		logic                      wr;
		logic [WORD_ADDR_BITS-1:0] addr;
		word_t                     data;
		begin_test("random");
		overlap0 = overlap_count;
		for (int i = 0; i < RANDOM_OPS && !timed_out; i++) begin
			rng  = xorshift(rng);
			addr = {23'd0, rng[6:0]};  // 32 blocks with 8 per set
			wr   = rng[7];
			rng  = xorshift(rng);
			do_request(wr, addr, rng, stalls, data);
		end
		check_value("read/write overlap", 0, overlap_count - overlap0);
		end_test();
	endtask

	initial begin
		for (int a = 0; a < SHADOW_WORDS; a++) begin
			shadow[a] = pattern_word(a);
		end
		rst_n      = 1'b0;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		directed_tests();
		if (!timed_out) begin
			random_test();
		end

		$display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: dcache.f
verilog/dcache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_tag_store.sv
verilog/cache_data_store.sv
verilog/cache_ctrl.sv
verilog/dcache.sv
dv/slow_mem_model.sv
dv/dcache_tb.sv
